//--- exu_cfg.svh
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// Data and address width of the core.
`define EXU_XLEN 32

// Data memory depth in words. Byte addresses at or above
// EXU_DMEM_WORDS * EXU_LANES are out of range.
`define EXU_DMEM_WORDS 256

// Byte lanes per word. This sets the bank count and the strobe width.
`define EXU_LANES 4

// Sequential pc step and the link value offset.
`define EXU_PC_INC 4

`endif

//--- exu_pkg.sv
package exu_pkg;

    // ALU function select.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_fn_e;

    typedef enum logic [1:0] {
        SRC_A_ZERO,
        SRC_A_PC,
        SRC_A_RS1
    } src_a_e;

    typedef enum logic [1:0] {
        SRC_B_IMM,
        SRC_B_RS2,
        SRC_B_FOUR
    } src_b_e;

    // MEM_NONE marks an instruction that does not touch the data memory.
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;

    typedef enum logic [1:0] {
        PC_SEQ,
        PC_BRANCH,
        PC_JAL,
        PC_JALR
    } pc_sel_e;

    typedef enum logic [2:0] {
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_cond_e;

    // One decoded instruction as handed over by the decoder.
    typedef struct packed {
        alu_fn_e   alu_fn;
        src_a_e    src_a;
        src_b_e    src_b;
        mem_size_e mem_size;
        logic      mem_store;
        logic      mem_signed;
        pc_sel_e   pc_sel;
        br_cond_e  br_cond;
        logic      link;
        logic      ebreak;
    } exu_op_t;

endpackage

//--- apb_if.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

interface apb_if;

    logic [`EXU_XLEN-1:0]  paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`EXU_XLEN-1:0]  pwdata;
    logic [`EXU_LANES-1:0] pstrb;
    logic [`EXU_XLEN-1:0]  prdata;
    logic                  pready;
    logic                  pslverr;

    modport master (
        output paddr, psel, penable, pwrite, pwdata, pstrb,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  paddr, psel, penable, pwrite, pwdata, pstrb,
        output prdata, pready, pslverr
    );

endinterface

//--- exu_alu.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_alu (
    input  exu_pkg::alu_fn_e     fn,
    input  exu_pkg::br_cond_e    cond,
    input  logic [`EXU_XLEN-1:0] a,
    input  logic [`EXU_XLEN-1:0] b,
    output logic [`EXU_XLEN-1:0] res,
    output logic                 taken
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    // RV32I shifts only look at the low five bits of the amount.
    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (fn)
            exu_pkg::ALU_ADD:    res = a + b;
            exu_pkg::ALU_SUB:    res = a - b;
            exu_pkg::ALU_SLL:    res = a << shamt;
            exu_pkg::ALU_SLT:    res = {{(`EXU_XLEN-1){1'b0}}, lt_s};
            exu_pkg::ALU_SLTU:   res = {{(`EXU_XLEN-1){1'b0}}, lt_u};
            exu_pkg::ALU_XOR:    res = a ^ b;
            exu_pkg::ALU_SRL:    res = a >> shamt;
            exu_pkg::ALU_SRA:    res = $unsigned($signed(a) >>> shamt);
            exu_pkg::ALU_OR:     res = a | b;
            exu_pkg::ALU_AND:    res = a & b;
            exu_pkg::ALU_PASS_B: res = b;
            default:             res = '0;
        endcase
    end

    // The branch compare runs beside the main function, so a branch
    // can use rs1 and rs2 while the ALU result goes unused.
    always_comb begin
        case (cond)
            exu_pkg::BR_EQ:  taken = a == b;
            exu_pkg::BR_NE:  taken = a != b;
            exu_pkg::BR_LT:  taken = lt_s;
            exu_pkg::BR_GE:  taken = !lt_s;
            exu_pkg::BR_LTU: taken = lt_u;
            exu_pkg::BR_GEU: taken = !lt_u;
            default:         taken = 1'b0;
        endcase
    end

endmodule

//--- exu_lsu.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_lsu (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic [`EXU_XLEN-1:0]  addr,
    input  logic [`EXU_XLEN-1:0]  wdata,
    input  exu_pkg::mem_size_e    size,
    input  logic                  store,
    input  logic                  signed_ld,
    output logic                  done,
    output logic [`EXU_XLEN-1:0]  ldata,
    output logic                  err,
    apb_if.master                 apb
);

    typedef enum logic [1:0] {L_IDLE, L_SETUP, L_ACCESS} lsu_state_e;

    lsu_state_e            state;
    exu_pkg::mem_size_e    size_q;
    logic                  signed_q;
    logic [`EXU_LANES-1:0] strb_base;
    logic [`EXU_XLEN-1:0]  rshift;

    assign apb.psel    = state != L_IDLE;
    assign apb.penable = state == L_ACCESS;

    always_comb begin
        case (size)
            exu_pkg::MEM_BYTE: strb_base = `EXU_LANES'(4'b0001);
            exu_pkg::MEM_HALF: strb_base = `EXU_LANES'(4'b0011);
            exu_pkg::MEM_WORD: strb_base = `EXU_LANES'(4'b1111);
            default:           strb_base = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= L_IDLE;
            apb.pwrite <= 1'b0;
        end else begin
            case (state)
                L_IDLE: begin
                    if (start) begin
                        state      <= L_SETUP;
                        apb.pwrite <= store;
                    end
                end
                L_SETUP: state <= L_ACCESS;
                L_ACCESS: begin
                    if (apb.pready) begin
                        state <= L_IDLE;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    // Store data moves into the addressed lane. Reads carry no strobes.
    always_ff @(posedge clk) begin
        if (state == L_IDLE && start) begin
            apb.paddr  <= addr;
            apb.pwdata <= wdata << {addr[1:0], 3'b000};
            apb.pstrb  <= store ? strb_base << addr[1:0] : '0;
            size_q     <= size;
            signed_q   <= signed_ld;
        end
    end

    // Load data is taken straight off the bus in the access cycle.
    assign rshift = apb.prdata >> {apb.paddr[1:0], 3'b000};

    always_comb begin
        case (size_q)
            exu_pkg::MEM_BYTE:
                ldata = {{(`EXU_XLEN-8){signed_q & rshift[7]}}, rshift[7:0]};
            exu_pkg::MEM_HALF:
                ldata = {{(`EXU_XLEN-16){signed_q & rshift[15]}}, rshift[15:0]};
            default:
                ldata = apb.prdata;
        endcase
    end

    assign done = (state == L_ACCESS) && apb.pready;
    assign err  = apb.pslverr;

endmodule

//--- exu_core.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_core (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  exu_pkg::exu_op_t     op,
    input  logic [`EXU_XLEN-1:0] rs1_d,
    input  logic [`EXU_XLEN-1:0] rs2_d,
    input  logic [`EXU_XLEN-1:0] imm,
    input  logic [`EXU_XLEN-1:0] pc,
    output logic                 out_valid,
    output logic [`EXU_XLEN-1:0] rd_d,
    output logic [`EXU_XLEN-1:0] dnpc,
    output logic                 mem_err,
    output logic                 halted,
    output logic [`EXU_XLEN-1:0] halt_code,
    apb_if.master                apb
);

    typedef enum logic [1:0] {S_IDLE, S_EXEC, S_MEM} state_e;

    state_e               state;
    exu_pkg::exu_op_t     op_q;
    logic [`EXU_XLEN-1:0] rs1_q;
    logic [`EXU_XLEN-1:0] rs2_q;
    logic [`EXU_XLEN-1:0] imm_q;
    logic [`EXU_XLEN-1:0] pc_q;
    logic [`EXU_XLEN-1:0] alu_a;
    logic [`EXU_XLEN-1:0] alu_b;
    logic [`EXU_XLEN-1:0] alu_res;
    logic                 alu_taken;
    logic [`EXU_XLEN-1:0] seq_pc;
    logic [`EXU_XLEN-1:0] tgt_pc;
    logic [`EXU_XLEN-1:0] dnpc_nxt;
    logic [`EXU_XLEN-1:0] rd_nxt;
    logic                 lsu_done;
    logic [`EXU_XLEN-1:0] lsu_ldata;
    logic                 lsu_err;
    logic                 accept;
    logic                 is_mem;
    logic                 emit;

    assign accept = in_valid && in_ready;
    assign is_mem = op_q.mem_size != exu_pkg::MEM_NONE;
    assign emit   = ((state == S_EXEC) && !is_mem) || ((state == S_MEM) && lsu_done);

    always_comb begin
        case (op_q.src_a)
            exu_pkg::SRC_A_PC:  alu_a = pc_q;
            exu_pkg::SRC_A_RS1: alu_a = rs1_q;
            default:            alu_a = '0;
        endcase
        case (op_q.src_b)
            exu_pkg::SRC_B_RS2:  alu_b = rs2_q;
            exu_pkg::SRC_B_FOUR: alu_b = `EXU_XLEN'(`EXU_PC_INC);
            default:             alu_b = imm_q;
        endcase
    end

    exu_alu i_alu (
        .fn    (op_q.alu_fn),
        .cond  (op_q.br_cond),
        .a     (alu_a),
        .b     (alu_b),
        .res   (alu_res),
        .taken (alu_taken)
    );

    // Loads and stores take their address from the ALU, rs1 plus imm.
    exu_lsu i_lsu (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     ((state == S_EXEC) && is_mem),
        .addr      (alu_res),
        .wdata     (rs2_q),
        .size      (op_q.mem_size),
        .store     (op_q.mem_store),
        .signed_ld (op_q.mem_signed),
        .done      (lsu_done),
        .ldata     (lsu_ldata),
        .err       (lsu_err),
        .apb       (apb)
    );

    // One adder serves every jump target. jalr starts from rs1, the rest from pc.
    assign seq_pc = pc_q + `EXU_XLEN'(`EXU_PC_INC);
    assign tgt_pc = ((op_q.pc_sel == exu_pkg::PC_JALR) ? rs1_q : pc_q) + imm_q;

    always_comb begin
        case (op_q.pc_sel)
            exu_pkg::PC_BRANCH: dnpc_nxt = alu_taken ? tgt_pc : seq_pc;
            exu_pkg::PC_JAL:    dnpc_nxt = tgt_pc;
            exu_pkg::PC_JALR:   dnpc_nxt = {tgt_pc[`EXU_XLEN-1:1], 1'b0};
            default:            dnpc_nxt = seq_pc;
        endcase
    end

    always_comb begin
        if (op_q.link) begin
            rd_nxt = seq_pc;
        end else if (is_mem && !op_q.mem_store) begin
            rd_nxt = lsu_ldata;
        end else begin
            rd_nxt = alu_res;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            in_ready  <= 1'b0;
            out_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            out_valid <= emit;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state    <= S_EXEC;
                        in_ready <= 1'b0;
                    end else begin
                        in_ready <= !halted;
                    end
                end
                S_EXEC: begin
                    if (is_mem) begin
                        state <= S_MEM;
                    end else begin
                        // An ebreak result closes the input for good.
                        state    <= S_IDLE;
                        in_ready <= !op_q.ebreak;
                        if (op_q.ebreak) begin
                            halted <= 1'b1;
                        end
                    end
                end
                S_MEM: begin
                    if (lsu_done) begin
                        state    <= S_IDLE;
                        in_ready <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= op;
            rs1_q <= rs1_d;
            rs2_q <= rs2_d;
            imm_q <= imm;
            pc_q  <= pc;
        end
        if (emit) begin
            rd_d    <= rd_nxt;
            dnpc    <= dnpc_nxt;
            mem_err <= (state == S_MEM) && lsu_err;
        end
        if (emit && op_q.ebreak) begin
            halt_code <= rs1_q;
        end
    end

endmodule

//--- dmem_bank.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module dmem_bank (
    input  logic                               clk,
    input  logic [$clog2(`EXU_DMEM_WORDS)-1:0] addr,
    input  logic                               we,
    input  logic [7:0]                         wdata,
    output logic [7:0]                         rdata
);

    logic [7:0] mem [`EXU_DMEM_WORDS];

    // The read port is registered and returns the old byte on a write.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- dmem_apb_slave.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module dmem_apb_slave (
    input  logic                                 clk,
    input  logic                                 arst_n,
    apb_if.slave                                 apb,
    output logic [$clog2(`EXU_DMEM_WORDS)-1:0]   lane_addr,
    output logic [`EXU_LANES-1:0]                lane_we,
    output logic [`EXU_LANES-1:0][7:0]           lane_wdata,
    input  logic [`EXU_LANES-1:0][7:0]           lane_rdata
);

    localparam int AW   = $clog2(`EXU_DMEM_WORDS);
    localparam int OFFW = $clog2(`EXU_LANES);

    logic setup;
    logic in_range;

    assign setup    = apb.psel && !apb.penable;
    assign in_range = apb.paddr < `EXU_XLEN'(`EXU_DMEM_WORDS * `EXU_LANES);

    // The banks see the word index every cycle. What they latch at the
    // end of setup is what the access cycle returns.
    assign lane_addr  = apb.paddr[OFFW +: AW];
    assign lane_wdata = apb.pwdata;

    always_comb begin
        for (int i = 0; i < `EXU_LANES; i++) begin
            lane_we[i] = setup && apb.pwrite && in_range && apb.pstrb[i];
        end
    end

    // Every transfer completes in its first access cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            apb.pready  <= 1'b0;
            apb.pslverr <= 1'b0;
        end else begin
            apb.pready  <= setup;
            apb.pslverr <= setup && !in_range;
        end
    end

    // An erroring read gives zero instead of whatever the banks hold.
    assign apb.prdata = apb.pslverr ? '0 : lane_rdata;

endmodule

//--- exu_top.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  exu_pkg::exu_op_t     op,
    input  logic [`EXU_XLEN-1:0] rs1_d,
    input  logic [`EXU_XLEN-1:0] rs2_d,
    input  logic [`EXU_XLEN-1:0] imm,
    input  logic [`EXU_XLEN-1:0] pc,
    output logic                 in_ready,
    output logic                 out_valid,
    output logic [`EXU_XLEN-1:0] rd_d,
    output logic [`EXU_XLEN-1:0] dnpc,
    output logic                 mem_err,
    output logic                 halted,
    output logic [`EXU_XLEN-1:0] halt_code
);

    logic [$clog2(`EXU_DMEM_WORDS)-1:0] lane_addr;
    logic [`EXU_LANES-1:0]              lane_we;
    logic [`EXU_LANES-1:0][7:0]         lane_wdata;
    logic [`EXU_LANES-1:0][7:0]         lane_rdata;

    apb_if i_apb ();

    exu_core i_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .rs1_d     (rs1_d),
        .rs2_d     (rs2_d),
        .imm       (imm),
        .pc        (pc),
        .out_valid (out_valid),
        .rd_d      (rd_d),
        .dnpc      (dnpc),
        .mem_err   (mem_err),
        .halted    (halted),
        .halt_code (halt_code),
        .apb       (i_apb.master)
    );

    dmem_apb_slave i_slave (
        .clk        (clk),
        .arst_n     (arst_n),
        .apb        (i_apb.slave),
        .lane_addr  (lane_addr),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata),
        .lane_rdata (lane_rdata)
    );

    // One byte-wide bank per lane. Lane 0 holds the lowest byte of a word.
    for (genvar g = 0; g < `EXU_LANES; g++) begin : g_lane
        dmem_bank i_bank (
            .clk   (clk),
            .addr  (lane_addr),
            .we    (lane_we[g]),
            .wdata (lane_wdata[g]),
            .rdata (lane_rdata[g])
        );
    end

endmodule

//--- tb_exu_top.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module tb_exu_top;

    typedef logic [`EXU_XLEN-1:0] word_t;

    localparam int MAX_ROWS = 64;

    logic             clk;
    logic             arst_n;
    logic             in_valid;
    exu_pkg::exu_op_t op;
    word_t            rs1_d;
    word_t            rs2_d;
    word_t            imm;
    word_t            pc;
    logic             in_ready;
    logic             out_valid;
    word_t            rd_d;
    word_t            dnpc;
    logic             mem_err;
    logic             halted;
    word_t            halt_code;

    // Stimulus and expected results, one entry per instruction.
    string            row_name [MAX_ROWS];
    exu_pkg::exu_op_t row_op   [MAX_ROWS];
    word_t            row_rs1  [MAX_ROWS];
    word_t            row_rs2  [MAX_ROWS];
    word_t            row_imm  [MAX_ROWS];
    word_t            row_pc   [MAX_ROWS];
    word_t            row_rd   [MAX_ROWS];
    word_t            row_npc  [MAX_ROWS];
    logic             row_err  [MAX_ROWS];
    logic             row_halt [MAX_ROWS];
    int               n_rows;

    exu_top i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op        (op),
        .rs1_d     (rs1_d),
        .rs2_d     (rs2_d),
        .imm       (imm),
        .pc        (pc),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .rd_d      (rd_d),
        .dnpc      (dnpc),
        .mem_err   (mem_err),
        .halted    (halted),
        .halt_code (halt_code)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic exu_pkg::exu_op_t alu_op(input exu_pkg::alu_fn_e fn,
                                                input exu_pkg::src_a_e sa,
                                                input exu_pkg::src_b_e sb);
        exu_pkg::exu_op_t o;
        o        = '0;
        o.alu_fn = fn;
        o.src_a  = sa;
        o.src_b  = sb;
        return o;
    endfunction

    function automatic exu_pkg::exu_op_t br_op(input exu_pkg::br_cond_e cond);
        exu_pkg::exu_op_t o;
        o         = alu_op(exu_pkg::ALU_ADD, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_RS2);
        o.pc_sel  = exu_pkg::PC_BRANCH;
        o.br_cond = cond;
        return o;
    endfunction

    function automatic exu_pkg::exu_op_t jump_op(input exu_pkg::pc_sel_e sel);
        exu_pkg::exu_op_t o;
        o        = alu_op(exu_pkg::ALU_ADD, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_IMM);
        o.pc_sel = sel;
        o.link   = 1'b1;
        return o;
    endfunction

    function automatic exu_pkg::exu_op_t mem_op(input exu_pkg::mem_size_e size,
                                                input logic store,
                                                input logic sgn);
        exu_pkg::exu_op_t o;
        o            = alu_op(exu_pkg::ALU_ADD, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_IMM);
        o.mem_size   = size;
        o.mem_store  = store;
        o.mem_signed = sgn;
        return o;
    endfunction

    // Reference for the RV32I register/immediate operations.
    function automatic word_t alu_model(input exu_pkg::alu_fn_e fn, input word_t a,
                                        input word_t b);
        int    sh;
        logic  a_lt_b;
        word_t r;
        sh     = int'(b % 32);
        a_lt_b = (a[31] != b[31]) ? a[31] : (a < b);
        case (fn)
            exu_pkg::ALU_ADD:  r = a + b;
            exu_pkg::ALU_SUB:  r = a + ~b + 32'd1;
            exu_pkg::ALU_SLL:  r = a << sh;
            exu_pkg::ALU_SLT:  r = a_lt_b ? 32'd1 : 32'd0;
            exu_pkg::ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            exu_pkg::ALU_XOR:  r = a ^ b;
            exu_pkg::ALU_SRL:  r = a >> sh;
            exu_pkg::ALU_SRA:  r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            exu_pkg::ALU_OR:   r = a | b;
            exu_pkg::ALU_AND:  r = a & b;
            default:           r = b;
        endcase
        return r;
    endfunction

    task automatic add_row(input string name, input exu_pkg::exu_op_t o, input word_t a,
                           input word_t b, input word_t i, input word_t p,
                           input word_t exp_rd, input word_t exp_npc, input logic err);
        row_name[n_rows] = name;
        row_op[n_rows]   = o;
        row_rs1[n_rows]  = a;
        row_rs2[n_rows]  = b;
        row_imm[n_rows]  = i;
        row_pc[n_rows]   = p;
        row_rd[n_rows]   = exp_rd;
        row_npc[n_rows]  = exp_npc;
        row_err[n_rows]  = err;
        row_halt[n_rows] = o.ebreak;
        n_rows++;
    endtask

    task automatic fill_table();
        word_t            a;
        word_t            b;
        word_t            c;
        word_t            p;
        exu_pkg::exu_op_t o;
        add_row("slt", alu_op(exu_pkg::ALU_SLT, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_RS2),
                32'hffff_ffff, 32'h1, 32'h0, 32'h1000, 32'h1, 32'h1004, 1'b0);
        add_row("sltu", alu_op(exu_pkg::ALU_SLTU, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_RS2),
                32'hffff_ffff, 32'h1, 32'h0, 32'h1000, 32'h0, 32'h1004, 1'b0);
        add_row("srl", alu_op(exu_pkg::ALU_SRL, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_IMM),
                32'h8000_0000, 32'h0, 32'h4, 32'h1000, 32'h0800_0000, 32'h1004, 1'b0);
        add_row("sra", alu_op(exu_pkg::ALU_SRA, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_IMM),
                32'h8000_0000, 32'h0, 32'h4, 32'h1000, 32'hf800_0000, 32'h1004, 1'b0);
        add_row("auipc", alu_op(exu_pkg::ALU_ADD, exu_pkg::SRC_A_PC, exu_pkg::SRC_B_IMM),
                32'h0, 32'h0, 32'h2000, 32'h1000, 32'h3000, 32'h1004, 1'b0);
        add_row("lui", alu_op(exu_pkg::ALU_PASS_B, exu_pkg::SRC_A_ZERO, exu_pkg::SRC_B_IMM),
                32'h0, 32'h0, 32'habcd_e000, 32'h1000, 32'habcd_e000, 32'h1004, 1'b0);
        add_row("pc_plus4", alu_op(exu_pkg::ALU_ADD, exu_pkg::SRC_A_PC, exu_pkg::SRC_B_FOUR),
                32'h0, 32'h0, 32'h0, 32'h1000, 32'h1004, 32'h1004, 1'b0);
        // Branches add rs1 and rs2 in the ALU, so rd_d carries that sum.
        add_row("beq_t", br_op(exu_pkg::BR_EQ), 32'h5, 32'h5, 32'h40, 32'h2000,
                32'ha, 32'h2040, 1'b0);
        add_row("beq_n", br_op(exu_pkg::BR_EQ), 32'h5, 32'h6, 32'h40, 32'h2000,
                32'hb, 32'h2004, 1'b0);
        add_row("bne_t_back", br_op(exu_pkg::BR_NE), 32'h5, 32'h6, 32'hffff_fff0, 32'h2000,
                32'hb, 32'h1ff0, 1'b0);
        add_row("bne_n", br_op(exu_pkg::BR_NE), 32'h5, 32'h5, 32'h40, 32'h2000,
                32'ha, 32'h2004, 1'b0);
        add_row("blt_t", br_op(exu_pkg::BR_LT), 32'hffff_ffff, 32'h1, 32'h40, 32'h2000,
                32'h0, 32'h2040, 1'b0);
        add_row("blt_n", br_op(exu_pkg::BR_LT), 32'h1, 32'hffff_ffff, 32'h40, 32'h2000,
                32'h0, 32'h2004, 1'b0);
        add_row("bge_t_eq", br_op(exu_pkg::BR_GE), 32'h7, 32'h7, 32'h40, 32'h2000,
                32'he, 32'h2040, 1'b0);
        add_row("bge_n", br_op(exu_pkg::BR_GE), 32'hffff_ffff, 32'h1, 32'h40, 32'h2000,
                32'h0, 32'h2004, 1'b0);
        add_row("bltu_t", br_op(exu_pkg::BR_LTU), 32'h1, 32'hffff_ffff, 32'h40, 32'h2000,
                32'h0, 32'h2040, 1'b0);
        add_row("bltu_n", br_op(exu_pkg::BR_LTU), 32'hffff_ffff, 32'h1, 32'h40, 32'h2000,
                32'h0, 32'h2004, 1'b0);
        add_row("bgeu_t", br_op(exu_pkg::BR_GEU), 32'hffff_ffff, 32'h1, 32'h40, 32'h2000,
                32'h0, 32'h2040, 1'b0);
        add_row("bgeu_n", br_op(exu_pkg::BR_GEU), 32'h1, 32'hffff_ffff, 32'h40, 32'h2000,
                32'h0, 32'h2004, 1'b0);
        add_row("jal", jump_op(exu_pkg::PC_JAL), 32'h1234_5678, 32'h0, 32'h100, 32'h3000,
                32'h3004, 32'h3100, 1'b0);
        add_row("jalr", jump_op(exu_pkg::PC_JALR), 32'h4001, 32'h0, 32'h10, 32'h3000,
                32'h3004, 32'h4010, 1'b0);
        // Stores return their address on rd_d, since that is the ALU result.
        add_row("sw_100", mem_op(exu_pkg::MEM_WORD, 1'b1, 1'b0), 32'h100, 32'h8877_6655,
                32'h0, 32'h4000, 32'h100, 32'h4004, 1'b0);
        add_row("sw_104", mem_op(exu_pkg::MEM_WORD, 1'b1, 1'b0), 32'h100, 32'h1122_3344,
                32'h4, 32'h4000, 32'h104, 32'h4004, 1'b0);
        add_row("sb_101", mem_op(exu_pkg::MEM_BYTE, 1'b1, 1'b0), 32'h101, 32'h0000_00a5,
                32'h0, 32'h4000, 32'h101, 32'h4004, 1'b0);
        add_row("sh_106", mem_op(exu_pkg::MEM_HALF, 1'b1, 1'b0), 32'h100, 32'h0000_c3d2,
                32'h6, 32'h4000, 32'h106, 32'h4004, 1'b0);
        add_row("lw_100", mem_op(exu_pkg::MEM_WORD, 1'b0, 1'b1), 32'h100, 32'h0,
                32'h0, 32'h4000, 32'h8877_a555, 32'h4004, 1'b0);
        add_row("lb_101", mem_op(exu_pkg::MEM_BYTE, 1'b0, 1'b1), 32'h101, 32'h0,
                32'h0, 32'h4000, 32'hffff_ffa5, 32'h4004, 1'b0);
        add_row("lbu_101", mem_op(exu_pkg::MEM_BYTE, 1'b0, 1'b0), 32'h101, 32'h0,
                32'h0, 32'h4000, 32'h0000_00a5, 32'h4004, 1'b0);
        add_row("lb_100", mem_op(exu_pkg::MEM_BYTE, 1'b0, 1'b1), 32'h0fc, 32'h0,
                32'h4, 32'h4000, 32'h0000_0055, 32'h4004, 1'b0);
        add_row("lh_102", mem_op(exu_pkg::MEM_HALF, 1'b0, 1'b1), 32'h102, 32'h0,
                32'h0, 32'h4000, 32'hffff_8877, 32'h4004, 1'b0);
        add_row("lhu_106", mem_op(exu_pkg::MEM_HALF, 1'b0, 1'b0), 32'h106, 32'h0,
                32'h0, 32'h4000, 32'h0000_c3d2, 32'h4004, 1'b0);
        add_row("lw_104", mem_op(exu_pkg::MEM_WORD, 1'b0, 1'b1), 32'h104, 32'h0,
                32'h0, 32'h4000, 32'hc3d2_3344, 32'h4004, 1'b0);
        add_row("lw_oor", mem_op(exu_pkg::MEM_WORD, 1'b0, 1'b1), 32'h400, 32'h0,
                32'h0, 32'h4000, 32'h0, 32'h4004, 1'b1);
        // 0x500 aliases word 0x100 in the low address bits and must not write it.
        add_row("sw_oor", mem_op(exu_pkg::MEM_WORD, 1'b1, 1'b0), 32'h500, 32'hdead_beef,
                32'h0, 32'h4000, 32'h500, 32'h4004, 1'b1);
        add_row("lbu_oor", mem_op(exu_pkg::MEM_BYTE, 1'b0, 1'b0), 32'hffff_fff8, 32'h0,
                32'h4, 32'h4000, 32'h0, 32'h4004, 1'b1);
        add_row("lw_100_again", mem_op(exu_pkg::MEM_WORD, 1'b0, 1'b1), 32'h100, 32'h0,
                32'h0, 32'h4000, 32'h8877_a555, 32'h4004, 1'b0);
        // The operand source that the ALU does not select carries its own value.
        for (int f = 0; f < 11; f++) begin
            for (int s = 0; s < 2; s++) begin
                a = $urandom;
                b = $urandom;
                c = $urandom;
                p = $urandom & 32'hffff_fffc;
                o = alu_op(exu_pkg::alu_fn_e'(f), exu_pkg::SRC_A_RS1,
                           (s == 0) ? exu_pkg::SRC_B_IMM : exu_pkg::SRC_B_RS2);
                add_row($sformatf("rand_fn%0d_src%0d", f, s), o, a,
                        (s == 0) ? c : b, (s == 0) ? b : c, p,
                        alu_model(exu_pkg::alu_fn_e'(f), a, b), p + 32'd4, 1'b0);
            end
        end
        o        = alu_op(exu_pkg::ALU_ADD, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_IMM);
        o.ebreak = 1'b1;
        add_row("ebreak", o, 32'h2a, 32'h0, 32'h10, 32'h5000, 32'h3a, 32'h5004, 1'b0);
    endtask

    task automatic check_value(input string name, input string what, input word_t exp,
                               input word_t got);
        assert (got === exp) else begin
            $display("** Error %s %s: expected %h, actual %h", name, what, exp, got);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic run_row(input int i);
        int lat;
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        op       = row_op[i];
        rs1_d    = row_rs1[i];
        rs2_d    = row_rs2[i];
        imm      = row_imm[i];
        pc       = row_pc[i];
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        lat      = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
            assert (out_valid || !in_ready) else begin
                $display("The core raised in_ready before the result of %s", row_name[i]);
                $display("TEST FAILED");
                $fatal(1);
            end
        end while (!out_valid);
        check_value(row_name[i], "rd_d", row_rd[i], rd_d);
        check_value(row_name[i], "dnpc", row_npc[i], dnpc);
        check_value(row_name[i], "mem_err", word_t'(row_err[i]), word_t'(mem_err));
        check_value(row_name[i], "halted", word_t'(row_halt[i]), word_t'(halted));
        if (row_halt[i]) begin
            check_value(row_name[i], "halt_code", row_rs1[i], halt_code);
        end
        // Memory ops spend two extra cycles in APB setup and access.
        check_value(row_name[i], "latency",
                    (row_op[i].mem_size != exu_pkg::MEM_NONE) ? 32'd3 : 32'd1, word_t'(lat));
    endtask

    task automatic check_halt_hold();
        in_valid = 1'b1;
        op       = alu_op(exu_pkg::ALU_ADD, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_IMM);
        repeat (20) begin
            @(posedge clk);
            #1;
            assert (!in_ready && !out_valid && halted) else begin
                $display("The core accepted or produced a result after the ebreak halt");
                $display("TEST FAILED");
                $fatal(1);
            end
        end
        in_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(99353));
        arst_n   = 1'b0;
        in_valid = 1'b0;
        op       = '0;
        rs1_d    = '0;
        rs2_d    = '0;
        imm      = '0;
        pc       = '0;
        n_rows   = 0;
        fill_table();
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_value("reset", "in_ready", 32'd0, word_t'(in_ready));
        check_value("reset", "out_valid", 32'd0, word_t'(out_valid));
        check_value("reset", "halted", 32'd0, word_t'(halted));
        @(posedge clk);
        #1;
        check_value("reset", "in_ready rise", 32'd1, word_t'(in_ready));
        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        check_halt_hold();
        $display("TEST OK");
        $finish;
    end

    // Generous bound of ten cycles per row plus reset and the halt check.
    initial begin
        int limit;
        #1;
        limit = n_rows * 10 + 100;
        repeat (limit) @(posedge clk);
        $display("No result arrived within %0d cycles", limit);
        $display("TEST FAILED");
        $fatal(1);
    end

endmodule

//--- exu.f
+incdir+.
exu_pkg.sv
apb_if.sv
exu_alu.sv
exu_lsu.sv
exu_core.sv
dmem_bank.sv
dmem_apb_slave.sv
exu_top.sv
tb_exu_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_exu_top \
    -f exu.f

./obj_dir/Vtb_exu_top
